// ==== design/soc_pkg.sv ====
package soc_pkg;

    // ----------------------------------------
    // Bus sizes
    // ----------------------------------------
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    // Value of address bits 31..24 that selects the CLINT
    localparam logic [7:0] clint_region = 8'h02;

    // CLINT register offsets within the low 16 address bits
    localparam logic [15:0] mtimecmp_lo_off = 16'h4000;
    localparam logic [15:0] mtimecmp_hi_off = 16'h4004;
    localparam logic [15:0] mtime_lo_off    = 16'hbff8;
    localparam logic [15:0] mtime_hi_off    = 16'hbffc;

    // SRAM depth in 32-bit words
    localparam int sram_words = 256;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // ----------------------------------------
    // State types
    // ----------------------------------------
    typedef enum logic {
        route_sram,
        route_clint
    } route_t;

    typedef enum logic {
        rd_idle,
        rd_data
    } rd_state_t;

    typedef enum logic [1:0] {
        wr_idle,
        wr_data,
        wr_resp
    } wr_state_t;

endpackage

// ==== design/axi_xbar.sv ====
module axi_xbar (
    input  logic                         clock,
    input  logic                         rst_n,
    // Upstream manager port
    input  logic [soc_pkg::addr_w-1:0]   awaddr, araddr,
    input  logic [soc_pkg::id_w-1:0]     awid, arid,
    input  logic [7:0]                   awlen, arlen,
    input  logic [2:0]                   awsize, arsize,
    input  logic [1:0]                   awburst, arburst,
    input  logic [soc_pkg::data_w-1:0]   wdata,
    input  logic [soc_pkg::data_w/8-1:0] wstrb,
    input  logic                         awvalid, wvalid, wlast, bready, arvalid, rready,
    output logic                         awready, wready, bvalid, arready, rvalid, rlast,
    output logic [1:0]                   bresp, rresp,
    output logic [soc_pkg::id_w-1:0]     bid, rid,
    output logic [soc_pkg::data_w-1:0]   rdata,
    // CLINT subordinate port
    output logic [soc_pkg::addr_w-1:0]   clint_awaddr, clint_araddr,
    output logic [soc_pkg::id_w-1:0]     clint_awid, clint_arid,
    output logic [7:0]                   clint_awlen, clint_arlen,
    output logic [2:0]                   clint_awsize, clint_arsize,
    output logic [1:0]                   clint_awburst, clint_arburst,
    output logic [soc_pkg::data_w-1:0]   clint_wdata,
    output logic [soc_pkg::data_w/8-1:0] clint_wstrb,
    output logic                         clint_awvalid, clint_wvalid, clint_wlast,
    output logic                         clint_bready, clint_arvalid, clint_rready,
    input  logic                         clint_awready, clint_wready, clint_bvalid,
    input  logic                         clint_arready, clint_rvalid, clint_rlast,
    input  logic [1:0]                   clint_bresp, clint_rresp,
    input  logic [soc_pkg::id_w-1:0]     clint_bid, clint_rid,
    input  logic [soc_pkg::data_w-1:0]   clint_rdata,
    // SRAM subordinate port
    output logic [soc_pkg::addr_w-1:0]   sram_awaddr, sram_araddr,
    output logic [soc_pkg::id_w-1:0]     sram_awid, sram_arid,
    output logic [7:0]                   sram_awlen, sram_arlen,
    output logic [2:0]                   sram_awsize, sram_arsize,
    output logic [1:0]                   sram_awburst, sram_arburst,
    output logic [soc_pkg::data_w-1:0]   sram_wdata,
    output logic [soc_pkg::data_w/8-1:0] sram_wstrb,
    output logic                         sram_awvalid, sram_wvalid, sram_wlast,
    output logic                         sram_bready, sram_arvalid, sram_rready,
    input  logic                         sram_awready, sram_wready, sram_bvalid,
    input  logic                         sram_arready, sram_rvalid, sram_rlast,
    input  logic [1:0]                   sram_bresp, sram_rresp,
    input  logic [soc_pkg::id_w-1:0]     sram_bid, sram_rid,
    input  logic [soc_pkg::data_w-1:0]   sram_rdata
);
    import soc_pkg::*;

    route_t rd_route;
    route_t wr_route;
    logic   rd_busy;
    logic   wr_busy;
    logic   rd_c;
    logic   wr_c;

    // Latched route while busy, live address decode while idle
    assign rd_c = rd_busy ? (rd_route == route_clint) : (araddr[31:24] == clint_region);
    assign wr_c = wr_busy ? (wr_route == route_clint) : (awaddr[31:24] == clint_region);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_busy  <= 1'b0;
            wr_busy  <= 1'b0;
            rd_route <= route_sram;
            wr_route <= route_sram;
        end else begin
            if (arvalid && arready) begin
                rd_busy  <= 1'b1;
                rd_route <= rd_c ? route_clint : route_sram;
            end else if (rvalid && rready && rlast) begin
                rd_busy <= 1'b0;
            end
            if (awvalid && awready) begin
                wr_busy  <= 1'b1;
                wr_route <= wr_c ? route_clint : route_sram;
            end else if (bvalid && bready) begin
                wr_busy <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Read channels
    // ----------------------------------------
    assign arready       = !rd_busy && (rd_c ? clint_arready : sram_arready);
    assign clint_arvalid = arvalid && !rd_busy && rd_c;
    assign sram_arvalid  = arvalid && !rd_busy && !rd_c;
    assign {clint_araddr, clint_arid, clint_arlen, clint_arsize, clint_arburst} =
        rd_c ? {araddr, arid, arlen, arsize, arburst} : '0;
    assign {sram_araddr, sram_arid, sram_arlen, sram_arsize, sram_arburst} =
        rd_c ? '0 : {araddr, arid, arlen, arsize, arburst};
    assign clint_rready  = rready && rd_c;
    assign sram_rready   = rready && !rd_c;
    assign {rvalid, rdata, rresp, rlast, rid} = rd_c ?
        {clint_rvalid, clint_rdata, clint_rresp, clint_rlast, clint_rid} :
        {sram_rvalid, sram_rdata, sram_rresp, sram_rlast, sram_rid};

    // ----------------------------------------
    // Write channels
    // ----------------------------------------
    assign awready       = !wr_busy && (wr_c ? clint_awready : sram_awready);
    assign clint_awvalid = awvalid && !wr_busy && wr_c;
    assign sram_awvalid  = awvalid && !wr_busy && !wr_c;
    assign {clint_awaddr, clint_awid, clint_awlen, clint_awsize, clint_awburst} =
        wr_c ? {awaddr, awid, awlen, awsize, awburst} : '0;
    assign {sram_awaddr, sram_awid, sram_awlen, sram_awsize, sram_awburst} =
        wr_c ? '0 : {awaddr, awid, awlen, awsize, awburst};
    assign wready = wr_c ? clint_wready : sram_wready;
    assign {clint_wvalid, clint_wdata, clint_wstrb, clint_wlast} =
        wr_c ? {wvalid, wdata, wstrb, wlast} : '0;
    assign {sram_wvalid, sram_wdata, sram_wstrb, sram_wlast} =
        wr_c ? '0 : {wvalid, wdata, wstrb, wlast};
    assign clint_bready = bready && wr_c;
    assign sram_bready  = bready && !wr_c;
    assign {bvalid, bresp, bid} = wr_c ?
        {clint_bvalid, clint_bresp, clint_bid} : {sram_bvalid, sram_bresp, sram_bid};

    // One read target at a time
    assert property (@(posedge clock) disable iff (!rst_n)
        !(clint_arvalid && sram_arvalid));

    // Read data only comes back for an accepted request
    assert property (@(posedge clock) disable iff (!rst_n) rvalid |-> rd_busy);

endmodule

// ==== design/clint.sv ====
module clint (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic [soc_pkg::addr_w-1:0]   awaddr, araddr,
    input  logic [soc_pkg::id_w-1:0]     awid, arid,
    input  logic [7:0]                   awlen, arlen,
    input  logic [soc_pkg::data_w-1:0]   wdata,
    input  logic [soc_pkg::data_w/8-1:0] wstrb,
    input  logic                         awvalid, wvalid, wlast, bready, arvalid, rready,
    output logic                         awready, wready, bvalid, arready, rvalid, rlast,
    output logic [1:0]                   bresp, rresp,
    output logic [soc_pkg::id_w-1:0]     bid, rid,
    output logic [soc_pkg::data_w-1:0]   rdata,
    output logic                         timer_irq
);
    import soc_pkg::*;

    logic [63:0]       mtime;
    logic [63:0]       mtimecmp;
    rd_state_t         rd_state;
    wr_state_t         wr_state;
    logic [7:0]        rd_cnt;
    logic [15:0]       wr_off;
    logic              wr_burst;
    logic              wr_hit;
    logic              rd_hit;
    logic [data_w-1:0] rd_word;

    assign rvalid = (rd_state == rd_data);
    assign wready = (wr_state == wr_data);
    assign bvalid = (wr_state == wr_resp);

    // Register lookup on the live read address
    always_comb begin
        rd_hit = 1'b1;
        case (araddr[15:0])
            mtimecmp_lo_off: rd_word = mtimecmp[31:0];
            mtimecmp_hi_off: rd_word = mtimecmp[63:32];
            mtime_lo_off:    rd_word = mtime[31:0];
            mtime_hi_off:    rd_word = mtime[63:32];
            default: begin
                rd_word = '0;
                rd_hit  = 1'b0;
            end
        endcase
    end

    assign wr_hit = (wr_off == mtimecmp_lo_off) || (wr_off == mtimecmp_hi_off) ||
                    (wr_off == mtime_lo_off) || (wr_off == mtime_hi_off);

    // ----------------------------------------
    // Timer and compare
    // ----------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mtime     <= '0;
            mtimecmp  <= '1;
            timer_irq <= 1'b0;
        end else begin
            mtime     <= mtime + 64'd1;
            timer_irq <= (mtime >= mtimecmp);
            // mtime itself is read only
            if (wvalid && wready && !wr_burst) begin
                for (int i = 0; i < data_w / 8; i++) begin
                    if (wstrb[i] && wr_off == mtimecmp_lo_off) begin
                        mtimecmp[8*i +: 8] <= wdata[8*i +: 8];
                    end
                    if (wstrb[i] && wr_off == mtimecmp_hi_off) begin
                        mtimecmp[32+8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= rd_idle;
            arready  <= 1'b0;
            rlast    <= 1'b0;
        end else if (rd_state == rd_idle) begin
            arready <= 1'b1;
            if (arvalid && arready) begin
                rd_state <= rd_data;
                arready  <= 1'b0;
                rlast    <= (arlen == 8'd0);
            end
        end else if (rready) begin
            rlast <= (rd_cnt == 8'd1);
            if (rlast) begin
                rd_state <= rd_idle;
                arready  <= 1'b1;
            end
        end
    end

    // Bursts get SLVERR and zero data on every beat
    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            rid    <= arid;
            rd_cnt <= arlen;
            if (arlen == 8'd0 && rd_hit) begin
                rdata <= rd_word;
                rresp <= resp_okay;
            end else begin
                rdata <= '0;
                rresp <= resp_slverr;
            end
        end else if (rvalid && rready) begin
            rd_cnt <= rd_cnt - 8'd1;
        end
    end

    // ----------------------------------------
    // Write path
    // ----------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= wr_idle;
            awready  <= 1'b0;
        end else begin
            case (wr_state)
                wr_idle: begin
                    awready <= 1'b1;
                    if (awvalid && awready) begin
                        wr_state <= wr_data;
                        awready  <= 1'b0;
                    end
                end
                wr_data: begin
                    if (wvalid && wlast) begin
                        wr_state <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (bready) begin
                        wr_state <= wr_idle;
                        awready  <= 1'b1;
                    end
                end
                default: wr_state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (awvalid && awready) begin
            bid      <= awid;
            wr_off   <= awaddr[15:0];
            wr_burst <= (awlen != 8'd0);
        end
        if (wvalid && wready) begin
            bresp <= (wr_hit && !wr_burst) ? resp_okay : resp_slverr;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n) rlast |-> rvalid);

endmodule

// ==== design/axi_sram.sv ====
module axi_sram (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic [soc_pkg::addr_w-1:0]   awaddr, araddr,
    input  logic [soc_pkg::id_w-1:0]     awid, arid,
    input  logic [7:0]                   awlen, arlen,
    input  logic [2:0]                   awsize, arsize,
    input  logic [1:0]                   awburst, arburst,
    input  logic [soc_pkg::data_w-1:0]   wdata,
    input  logic [soc_pkg::data_w/8-1:0] wstrb,
    input  logic                         awvalid, wvalid, wlast, bready, arvalid, rready,
    output logic                         awready, wready, bvalid, arready, rvalid, rlast,
    output logic [1:0]                   bresp, rresp,
    output logic [soc_pkg::id_w-1:0]     bid, rid,
    output logic [soc_pkg::data_w-1:0]   rdata
);
    import soc_pkg::*;

    logic [data_w-1:0] mem [sram_words];
    rd_state_t         rd_state;
    wr_state_t         wr_state;
    logic [7:0]        rd_cnt;
    logic [addr_w-1:0] rd_addr;
    logic [addr_w-1:0] rd_next;
    logic [addr_w-1:0] wr_addr;

    assign rvalid  = (rd_state == rd_data);
    assign rresp   = resp_okay;
    assign wready  = (wr_state == wr_data);
    assign bvalid  = (wr_state == wr_resp);
    assign bresp   = resp_okay;
    assign rd_next = rd_addr + addr_w'(4);

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= rd_idle;
            arready  <= 1'b0;
            rlast    <= 1'b0;
        end else if (rd_state == rd_idle) begin
            arready <= 1'b1;
            if (arvalid && arready) begin
                rd_state <= rd_data;
                arready  <= 1'b0;
                rlast    <= (arlen == 8'd0);
            end
        end else if (rready) begin
            rlast <= (rd_cnt == 8'd1);
            if (rlast) begin
                rd_state <= rd_idle;
                arready  <= 1'b1;
            end
        end
    end

    // Every burst is INCR, word index from bits 9..2
    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            rid     <= arid;
            rd_cnt  <= arlen;
            rd_addr <= araddr;
            rdata   <= mem[araddr[9:2]];
        end else if (rvalid && rready && !rlast) begin
            rd_cnt  <= rd_cnt - 8'd1;
            rd_addr <= rd_next;
            rdata   <= mem[rd_next[9:2]];
        end
    end

    // ----------------------------------------
    // Write path
    // ----------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= wr_idle;
            awready  <= 1'b0;
        end else begin
            case (wr_state)
                wr_idle: begin
                    awready <= 1'b1;
                    if (awvalid && awready) begin
                        wr_state <= wr_data;
                        awready  <= 1'b0;
                    end
                end
                wr_data: begin
                    if (wvalid && wlast) begin
                        wr_state <= wr_resp;
                    end
                end
                wr_resp: begin
                    if (bready) begin
                        wr_state <= wr_idle;
                        awready  <= 1'b1;
                    end
                end
                default: wr_state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (awvalid && awready) begin
            bid     <= awid;
            wr_addr <= awaddr;
        end
        if (wvalid && wready) begin
            for (int i = 0; i < data_w / 8; i++) begin
                if (wstrb[i]) begin
                    mem[wr_addr[9:2]][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
            wr_addr <= wr_addr + addr_w'(4);
        end
    end

    // Stalled beat keeps its payload
    assert property (@(posedge clock) disable iff (!rst_n)
        rvalid && !rready |=> $stable(rdata) && $stable(rlast));

    // Full-word beats only, never the reserved burst type
    assert property (@(posedge clock) disable iff (!rst_n)
        awvalid && awready |-> awsize == 3'd2 && awburst != 2'b11);
    assert property (@(posedge clock) disable iff (!rst_n)
        arvalid && arready |-> arsize == 3'd2 && arburst != 2'b11);

endmodule

// ==== design/mem_subsys.sv ====
module mem_subsys (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic [soc_pkg::addr_w-1:0]   awaddr, araddr,
    input  logic [soc_pkg::id_w-1:0]     awid, arid,
    input  logic [7:0]                   awlen, arlen,
    input  logic [2:0]                   awsize, arsize,
    input  logic [1:0]                   awburst, arburst,
    input  logic [soc_pkg::data_w-1:0]   wdata,
    input  logic [soc_pkg::data_w/8-1:0] wstrb,
    input  logic                         awvalid, wvalid, wlast, bready, arvalid, rready,
    output logic                         awready, wready, bvalid, arready, rvalid, rlast,
    output logic [1:0]                   bresp, rresp,
    output logic [soc_pkg::id_w-1:0]     bid, rid,
    output logic [soc_pkg::data_w-1:0]   rdata,
    output logic                         timer_irq
);
    import soc_pkg::*;

    // ----------------------------------------
    // Crossbar to CLINT
    // ----------------------------------------
    logic [addr_w-1:0]   clint_awaddr, clint_araddr;
    logic [id_w-1:0]     clint_awid, clint_bid, clint_arid, clint_rid;
    logic [7:0]          clint_awlen, clint_arlen;
    logic [data_w-1:0]   clint_wdata, clint_rdata;
    logic [data_w/8-1:0] clint_wstrb;
    logic [1:0]          clint_bresp, clint_rresp;
    logic                clint_awvalid, clint_awready, clint_wvalid, clint_wready;
    logic                clint_wlast, clint_bvalid, clint_bready, clint_arvalid;
    logic                clint_arready, clint_rready, clint_rvalid, clint_rlast;

    // ----------------------------------------
    // Crossbar to SRAM
    // ----------------------------------------
    logic [addr_w-1:0]   sram_awaddr, sram_araddr;
    logic [id_w-1:0]     sram_awid, sram_bid, sram_arid, sram_rid;
    logic [7:0]          sram_awlen, sram_arlen;
    logic [2:0]          sram_awsize, sram_arsize;
    logic [1:0]          sram_awburst, sram_arburst, sram_bresp, sram_rresp;
    logic [data_w-1:0]   sram_wdata, sram_rdata;
    logic [data_w/8-1:0] sram_wstrb;
    logic                sram_awvalid, sram_awready, sram_wvalid, sram_wready;
    logic                sram_wlast, sram_bvalid, sram_bready, sram_arvalid;
    logic                sram_arready, sram_rready, sram_rvalid, sram_rlast;

    // CLINT ignores size and burst type
    axi_xbar xbar_i (
        .*,
        .clint_awsize  (),
        .clint_awburst (),
        .clint_arsize  (),
        .clint_arburst ()
    );

    clint clint_i (
        .clock(clock), .rst_n(rst_n),
        .awaddr(clint_awaddr), .araddr(clint_araddr),
        .awid(clint_awid), .arid(clint_arid), .awlen(clint_awlen), .arlen(clint_arlen),
        .wdata(clint_wdata), .wstrb(clint_wstrb),
        .awvalid(clint_awvalid), .wvalid(clint_wvalid), .wlast(clint_wlast),
        .bready(clint_bready), .arvalid(clint_arvalid), .rready(clint_rready),
        .awready(clint_awready), .wready(clint_wready), .bvalid(clint_bvalid),
        .arready(clint_arready), .rvalid(clint_rvalid), .rlast(clint_rlast),
        .bresp(clint_bresp), .rresp(clint_rresp), .bid(clint_bid), .rid(clint_rid),
        .rdata(clint_rdata),
        .timer_irq(timer_irq)
    );

    axi_sram sram_i (
        .clock(clock), .rst_n(rst_n),
        .awaddr(sram_awaddr), .araddr(sram_araddr),
        .awid(sram_awid), .arid(sram_arid), .awlen(sram_awlen), .arlen(sram_arlen),
        .awsize(sram_awsize), .arsize(sram_arsize),
        .awburst(sram_awburst), .arburst(sram_arburst),
        .wdata(sram_wdata), .wstrb(sram_wstrb),
        .awvalid(sram_awvalid), .wvalid(sram_wvalid), .wlast(sram_wlast),
        .bready(sram_bready), .arvalid(sram_arvalid), .rready(sram_rready),
        .awready(sram_awready), .wready(sram_wready), .bvalid(sram_bvalid),
        .arready(sram_arready), .rvalid(sram_rvalid), .rlast(sram_rlast),
        .bresp(sram_bresp), .rresp(sram_rresp), .bid(sram_bid), .rid(sram_rid),
        .rdata(sram_rdata)
    );

endmodule

// ==== tests/mem_subsys_tb.sv ====
module mem_subsys_tb;
    import soc_pkg::*;

    localparam int max_records = 32;

    logic                clock;
    logic                rst_n;
    logic [addr_w-1:0]   awaddr, araddr;
    logic [id_w-1:0]     awid, arid, bid, rid;
    logic [7:0]          awlen, arlen;
    logic [2:0]          awsize, arsize;
    logic [1:0]          awburst, arburst, bresp, rresp;
    logic [data_w-1:0]   wdata, rdata;
    logic [data_w/8-1:0] wstrb;
    logic                awvalid, wvalid, wlast, bready, arvalid, rready;
    logic                awready, wready, bvalid, arready, rvalid, rlast;
    logic                timer_irq;

    // Six words per record: op, addr, len, strb, data, expect
    logic [31:0] trace [max_records*6];
    integer      seed = 32'hc186;
    int          errors = 0;
    int          n_rec = 0;
    int unsigned cycles = 0;
    int unsigned cycle_limit = 0;
    logic [31:0] last_mtime;

    mem_subsys mem_subsys_i (.*);

    always #5 clock = ~clock;

    // ----------------------------------------
    // Run length guard
    // ----------------------------------------
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: no progress after %0d cycles, run stopped", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // Ready three cycles out of four
    function automatic logic draw_ready();
        return ($random(seed) & 3) != 0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // ----------------------------------------
    // AXI manager
    // ----------------------------------------
    task automatic write_burst(input logic [31:0] addr, input int len, input logic [3:0] strb,
                               input logic [31:0] data, input logic [1:0] exp_resp,
                               input logic [3:0] id);
        int beat;
        bit done;
        @(negedge clock);
        awaddr  = addr;
        awlen   = 8'(len);
        awid    = id;
        awvalid = 1'b1;
        do @(posedge clock); while (!awready);
        @(negedge clock);
        awvalid = 1'b0;
        for (beat = 0; beat <= len; beat++) begin
            wdata  = data + 32'(beat);
            wstrb  = strb;
            wlast  = (beat == len);
            wvalid = 1'b1;
            do @(posedge clock); while (!wready);
            @(negedge clock);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        done   = 1'b0;
        while (!done) begin
            bready = draw_ready();
            @(posedge clock);
            if (bvalid && bready) begin
                check_value("bresp", 32'(bresp), 32'(exp_resp));
                check_value("bid", 32'(bid), 32'(id));
                done = 1'b1;
            end
            @(negedge clock);
        end
        bready = 1'b0;
    endtask

    task automatic read_burst(input logic [31:0] addr, input int len,
                              input logic [1:0] exp_resp, input logic [31:0] first,
                              input bit check_data, input logic [3:0] id,
                              output logic [31:0] got);
        int          beat;
        bit          stalled;
        logic [31:0] exp_data;
        @(negedge clock);
        araddr  = addr;
        arlen   = 8'(len);
        arid    = id;
        arvalid = 1'b1;
        do @(posedge clock); while (!arready);
        @(negedge clock);
        arvalid = 1'b0;
        beat    = 0;
        stalled = 1'b0;
        got     = '0;
        while (beat <= len) begin
            // One held cycle in the middle of every burst
            if (beat == 1 && !stalled) begin
                rready  = 1'b0;
                stalled = 1'b1;
            end else begin
                rready = draw_ready();
            end
            @(posedge clock);
            if (rvalid && rready) begin
                // Error beats carry zero data
                exp_data = (exp_resp == resp_okay) ? first + 32'(beat) : '0;
                if (check_data) begin
                    check_value("rdata", rdata, exp_data);
                end
                check_value("rresp", 32'(rresp), 32'(exp_resp));
                check_value("rlast", 32'(rlast), 32'(beat == len));
                check_value("rid", 32'(rid), 32'(id));
                got = rdata;
                beat++;
            end
            @(negedge clock);
        end
        rready = 1'b0;
    endtask

    initial begin
        int          idx;
        int          base;
        logic [31:0] op;
        logic [31:0] got;
        clock   = 1'b0;
        rst_n   = 1'b0;
        awaddr  = '0;
        araddr  = '0;
        awid    = '0;
        arid    = '0;
        awlen   = '0;
        arlen   = '0;
        awsize  = 3'd2;
        arsize  = 3'd2;
        awburst = 2'b01;
        arburst = 2'b01;
        wdata   = '0;
        wstrb   = '0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wlast   = 1'b0;
        bready  = 1'b0;
        arvalid = 1'b0;
        rready  = 1'b0;
        last_mtime = '0;
        $readmemh("tests/mem_subsys_trace.txt", trace);
        while (n_rec < max_records && trace[n_rec*6] != 32'hff) begin
            n_rec++;
        end
        if (n_rec == max_records) begin
            $display("Trace has no end marker within %0d records", max_records);
            errors++;
        end
        cycle_limit = 200 * n_rec + 20;
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        for (idx = 0; idx < n_rec; idx++) begin
            base = idx * 6;
            op   = trace[base];
            case (op)
                32'h0: write_burst(trace[base+1], int'(trace[base+2]), trace[base+3][3:0],
                                   trace[base+4], trace[base+5][1:0], 4'(idx));
                32'h1: read_burst(trace[base+1], int'(trace[base+2]), trace[base+3][1:0],
                                  trace[base+5], 1'b1, 4'(idx), got);
                32'h2: begin
                    read_burst(trace[base+1], 0, resp_okay, '0, 1'b0, 4'(idx), got);
                    if (got <= last_mtime) begin
                        $display("error: mtime_lo did not increase, %h after %h",
                                 got, last_mtime);
                        errors++;
                    end
                    last_mtime = got;
                end
                32'h3: begin
                    repeat (2) @(negedge clock);
                    check_value("timer_irq", 32'(timer_irq), trace[base+5]);
                end
                default: begin
                    $display("Unknown trace operation %h in record %0d", op, idx);
                    errors++;
                end
            endcase
        end

        $display("Finished %0d records with %0d errors", n_rec, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/mem_subsys_trace.txt ====
// Columns (hex): op addr len strb data expect
// op 0 write (expect = bresp), 1 read (strb = rresp), 2 mtime_lo read, 3 timer_irq, ff end
// SRAM single word
0 00000010 0 f a5a50001 0
1 00000010 0 0 0 a5a50001
// SRAM 4-beat bursts
0 00000100 3 f 10000000 0
1 00000100 3 0 0 10000000
// Byte strobes over a known word
0 00000020 0 f 11223344 0
0 00000020 0 3 aaaabbbb 0
1 00000020 0 0 0 1122bbbb
// Same low offset in SRAM and in the CLINT
0 00004000 0 f 5a5a5a5a 0
0 02004000 0 f 12345678 0
1 02004000 0 0 0 12345678
1 00004000 0 0 0 5a5a5a5a
// mtime runs, compare at zero then at all ones
2 0200bff8 0 0 0 0
2 0200bff8 0 0 0 0
0 02004004 0 f 0 0
0 02004000 0 f 0 0
3 0 0 0 0 1
0 02004000 0 f ffffffff 0
0 02004004 0 f ffffffff 0
3 0 0 0 0 0
// Unmapped CLINT offset, then a 2-beat CLINT read
1 02000010 0 2 0 0
1 02004000 1 2 0 0
// End marker
ff 0 0 0 0 0

// ==== project.f ====
design/soc_pkg.sv
design/axi_xbar.sv
design/clint.sv
design/axi_sram.sv
design/mem_subsys.sv
tests/mem_subsys_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run the simulation, then search the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --top-module mem_subsys_tb -f project.f -o mem_subsys_sim \
    && ./obj_dir/mem_subsys_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Test OK$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
